/* hdl/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic                          Clock,
    input  logic                          rstN,
    input  minisrcPkg::ctrlWord_t         ctrl,
    input  logic [minisrcPkg::DATA_W-1:0] bus,
    output logic [minisrcPkg::DATA_W-1:0] zLow
);

    localparam int W = minisrcPkg::DATA_W;

    logic [W-1:0] y, z, result;
    logic [2*W-1:0] yTwice; // rotates pick a window out of this
    logic [minisrcPkg::SHAMT_W-1:0] amount;

    assign amount = bus[minisrcPkg::SHAMT_W-1:0];
    assign yTwice = {y, y};

    always_comb begin
        case (ctrl.aluOp)
            minisrcPkg::aluAdd:  result = y + bus;
            minisrcPkg::aluSub:  result = y - bus;
            minisrcPkg::aluAnd:  result = y & bus;
            minisrcPkg::aluOr:   result = y | bus;
            minisrcPkg::aluShr:  result = y >> amount;
            minisrcPkg::aluShra: result = $signed(y) >>> amount;
            minisrcPkg::aluShl:  result = y << amount;
            minisrcPkg::aluRor:  result = yTwice[amount +: W];
            minisrcPkg::aluRol:  result = yTwice[(W - amount) +: W]; // amount 0 gives y
            default:             result = y + bus;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (ctrl.yLoad) y <= bus;
        if (ctrl.zLoad) z <= result;
    end

    assign zLow = z;

    yzExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(ctrl.yLoad && ctrl.zLoad))
        else $error("Y and Z loaded in the same step");

endmodule

`default_nettype wire

/* hdl/busRouter.sv */
`timescale 1ns/1ps
`default_nettype none

module busRouter (
    input  logic                          Clock,
    input  logic                          rstN,
    input  minisrcPkg::ctrlWord_t         ctrl,
    input  logic [minisrcPkg::DATA_W-1:0] regData,
    input  logic [minisrcPkg::DATA_W-1:0] pcValue,
    input  logic [minisrcPkg::DATA_W-1:0] mdrValue,
    input  logic [minisrcPkg::DATA_W-1:0] zLow,
    output logic [minisrcPkg::DATA_W-1:0] bus,
    output minisrcPkg::instr_t            instr
);

    localparam int W = minisrcPkg::DATA_W;
    localparam int C_W = minisrcPkg::IMM_W;

    minisrcPkg::instr_t ir;
    logic [W-1:0] imm;

    always_ff @(posedge Clock) begin
        if (!rstN) ir <= '0;
        else if (ctrl.irLoad) ir <= bus;
    end

    assign imm = {{(W - C_W){ir.immForm.c[C_W-1]}}, ir.immForm.c};

    always_comb begin
        case (ctrl.busSrc)
            minisrcPkg::srcReg:  bus = regData;
            minisrcPkg::srcPc:   bus = pcValue;
            minisrcPkg::srcMdr:  bus = mdrValue;
            minisrcPkg::srcZLow: bus = zLow;
            minisrcPkg::srcImm:  bus = imm;
            default:             bus = '0;
        endcase
    end

    assign instr = ir;

    irFromMdr: assert property (@(posedge Clock) disable iff (!rstN)
        ctrl.irLoad |-> ctrl.busSrc == minisrcPkg::srcMdr)
        else $error("IR loaded from a source other than MDR");

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                  Clock,
    input  logic                  rstN,
    input  minisrcPkg::instr_t    instr,
    input  logic                  memDone,
    output minisrcPkg::ctrlWord_t ctrl,
    output logic                  halted
);

    typedef enum logic [2:0] {
        stepT0, stepT1, stepT2, stepT3, stepT4, stepT5, stepT6, stepT7
    } step_t;

    step_t step;
    logic started; // first cycle after reset issues nothing
    minisrcPkg::opcode_t opcode;
    minisrcPkg::aluOp_t aluOpDec;
    logic isLd, isLdi, isSt, isAlu, isHalt, isMemOp;

    assign opcode = instr.regForm.opcode;
    assign isLd = (opcode == minisrcPkg::opLd);
    assign isLdi = (opcode == minisrcPkg::opLdi);
    assign isSt = (opcode == minisrcPkg::opSt);
    assign isHalt = (opcode == minisrcPkg::opHalt);
    assign isMemOp = isLd | isLdi | isSt; // base plus offset through the ALU

    always_comb begin
        isAlu = 1'b1;
        case (opcode)
            minisrcPkg::opAdd:  aluOpDec = minisrcPkg::aluAdd;
            minisrcPkg::opSub:  aluOpDec = minisrcPkg::aluSub;
            minisrcPkg::opAnd:  aluOpDec = minisrcPkg::aluAnd;
            minisrcPkg::opOr:   aluOpDec = minisrcPkg::aluOr;
            minisrcPkg::opShr:  aluOpDec = minisrcPkg::aluShr;
            minisrcPkg::opShra: aluOpDec = minisrcPkg::aluShra;
            minisrcPkg::opShl:  aluOpDec = minisrcPkg::aluShl;
            minisrcPkg::opRor:  aluOpDec = minisrcPkg::aluRor;
            minisrcPkg::opRol:  aluOpDec = minisrcPkg::aluRol;
            default: begin
                aluOpDec = minisrcPkg::aluAdd;
                isAlu = 1'b0;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            step <= stepT0;
            started <= 1'b0;
            halted <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started && !halted) begin
                case (step)
                    stepT0: step <= stepT1;
                    stepT1: if (memDone) step <= stepT2;
                    stepT2: step <= stepT3;
                    stepT3: begin
                        if (isHalt) halted <= 1'b1; // stays until reset
                        else if (isAlu || isMemOp) step <= stepT4;
                        else step <= stepT0; // unknown opcode
                    end
                    stepT4: step <= stepT5;
                    stepT5: step <= (isLd || isSt) ? stepT6 : stepT0;
                    stepT6: if (isSt || memDone) step <= stepT7;
                    stepT7: if (isLd || memDone) step <= stepT0;
                    default: step <= stepT0;
                endcase
            end
        end
    end

    always_comb begin
        ctrl = '0;
        ctrl.busSrc = minisrcPkg::srcNone;
        if (started && !halted) begin
            case (step)
                stepT0: begin
                    ctrl.busSrc = minisrcPkg::srcPc;
                    ctrl.marLoad = 1'b1;
                    ctrl.incPc = 1'b1;
                end
                stepT1: ctrl.memRead = 1'b1; // instruction fetch
                stepT2: begin
                    ctrl.busSrc = minisrcPkg::srcMdr;
                    ctrl.irLoad = 1'b1;
                end
                stepT3: begin
                    if (isAlu || isMemOp) begin
                        ctrl.busSrc = minisrcPkg::srcReg;
                        ctrl.regIndex = instr.regForm.rb;
                        ctrl.baGate = isMemOp;
                        ctrl.yLoad = 1'b1;
                    end
                end
                stepT4: begin
                    ctrl.busSrc = isMemOp ? minisrcPkg::srcImm : minisrcPkg::srcReg;
                    ctrl.regIndex = instr.regForm.rc;
                    ctrl.aluOp = aluOpDec; // add for memory ops
                    ctrl.zLoad = 1'b1;
                end
                stepT5: begin
                    ctrl.busSrc = minisrcPkg::srcZLow;
                    ctrl.regIndex = instr.regForm.ra;
                    ctrl.marLoad = isLd | isSt;
                    ctrl.regWrite = !(isLd | isSt);
                end
                stepT6: begin
                    if (isSt) begin
                        ctrl.busSrc = minisrcPkg::srcReg;
                        ctrl.regIndex = instr.regForm.ra;
                        ctrl.mdrLoad = 1'b1;
                    end else begin
                        ctrl.memRead = 1'b1;
                    end
                end
                stepT7: begin
                    if (isSt) begin
                        ctrl.memWrite = 1'b1;
                    end else begin
                        ctrl.busSrc = minisrcPkg::srcMdr;
                        ctrl.regIndex = instr.regForm.ra;
                        ctrl.regWrite = 1'b1;
                    end
                end
                default: ctrl = '0;
            endcase
        end
    end

    haltQuiet: assert property (@(posedge Clock) disable iff (!rstN)
        halted |=> halted && !ctrl.memRead && !ctrl.memWrite)
        else $error("memory step issued after halt");

endmodule

`default_nettype wire

/* hdl/memInterface.sv */
`timescale 1ns/1ps
`default_nettype none

module memInterface #(
    parameter int ADDR_W = 12
) (
    input  logic                              Clock,
    input  logic                              rstN,
    input  minisrcPkg::ctrlWord_t             ctrl,
    input  logic [minisrcPkg::DATA_W-1:0]     bus,
    input  logic                              memAck,
    input  logic [minisrcPkg::DATA_W-1:0]     memData,
    output logic                              memReq,
    output minisrcPkg::memCmd_t               memCmd,
    output logic                              memDone,
    output logic [minisrcPkg::DATA_W-1:0]     pcValue,
    output logic [minisrcPkg::DATA_W-1:0]     mdrValue
);

    typedef enum logic [1:0] {phIdle, phReq, phRel} phase_t;

    phase_t phase;
    logic [minisrcPkg::DATA_W-1:0] pc, mar, mdr;
    logic startReq, ackSeen;

    // no new request in the memDone cycle, the step is still the same
    assign startReq = (phase == phIdle) && (ctrl.memRead || ctrl.memWrite)
                      && !memDone && !memAck;
    assign ackSeen = (phase == phReq) && memAck;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= '0;
            phase <= phIdle;
            memReq <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= 1'b0;
            if (ctrl.incPc) pc <= pc + 1'b1; // word addressed
            case (phase)
                phIdle: if (startReq) begin
                    memReq <= 1'b1;
                    phase <= phReq;
                end
                phReq: if (memAck) begin
                    memReq <= 1'b0;
                    phase <= phRel;
                end
                phRel: if (!memAck) begin
                    memDone <= 1'b1;
                    phase <= phIdle;
                end
                default: phase <= phIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.marLoad) mar <= bus;
        if (ctrl.mdrLoad) mdr <= bus;
        else if (ackSeen && !memCmd.write) mdr <= memData; // read data
        if (startReq) begin
            memCmd.write <= ctrl.memWrite;
            memCmd.addr <= minisrcPkg::DATA_W'(mar[ADDR_W-1:0]);
            memCmd.wdata <= mdr;
        end
    end

    assign pcValue = pc;
    assign mdrValue = mdr;

    cmdStable: assert property (@(posedge Clock) disable iff (!rstN)
        memReq |=> !memReq || $stable(memCmd))
        else $error("memCmd changed during a request");

endmodule

`default_nettype wire

/* hdl/minisrcPkg.sv */
`default_nettype none

package minisrcPkg;

    localparam int DATA_W = 32;
    localparam int REG_CNT = 16;
    localparam int REG_IDX_W = $clog2(REG_CNT);
    localparam int IMM_W = 19;
    localparam int SHAMT_W = $clog2(DATA_W);

    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShra = 5'b01000,
        opShl  = 5'b01001,
        opRor  = 5'b01010,
        opRol  = 5'b01011,
        opHalt = 5'b11011
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        logic [REG_IDX_W-1:0] ra;
        logic [REG_IDX_W-1:0] rb;
        logic [REG_IDX_W-1:0] rc;
        logic [14:0] unused;
    } regForm_t;

    typedef struct packed {
        opcode_t opcode;
        logic [REG_IDX_W-1:0] ra;
        logic [REG_IDX_W-1:0] rb;
        logic [IMM_W-1:0] c; // sign extended on the bus
    } immForm_t;

    typedef union packed {
        regForm_t regForm;
        immForm_t immForm;
    } instr_t;

    typedef enum logic [2:0] {
        srcNone = 3'd0, // bus reads zero
        srcReg  = 3'd1,
        srcPc   = 3'd2,
        srcMdr  = 3'd3,
        srcZLow = 3'd4,
        srcImm  = 3'd5
    } busSrc_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShra, aluShl, aluRor, aluRol
    } aluOp_t;

    typedef struct packed {
        busSrc_t busSrc;
        logic [REG_IDX_W-1:0] regIndex;
        logic baGate;   // R0 reads as zero
        logic regWrite;
        logic marLoad;
        logic mdrLoad;
        logic incPc;
        logic irLoad;
        logic yLoad;
        logic zLoad;
        aluOp_t aluOp;
        logic memRead;  // held until memDone
        logic memWrite;
    } ctrlWord_t;

    // only the low ADDR_W bits of addr are driven, the rest stay zero
    typedef struct packed {
        logic write;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } memCmd_t;

endpackage

`default_nettype wire

/* hdl/minisrcTop.sv */
`timescale 1ns/1ps
`default_nettype none

module minisrcTop #(
    parameter int ADDR_W = 12
) (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          memAck,
    input  logic [minisrcPkg::DATA_W-1:0] memData,
    output logic                          memReq,
    output minisrcPkg::memCmd_t           memCmd,
    output logic                          halted
);

    minisrcPkg::ctrlWord_t ctrl;
    minisrcPkg::instr_t instr;
    logic [minisrcPkg::DATA_W-1:0] bus;
    logic [minisrcPkg::DATA_W-1:0] regData, pcValue, mdrValue, zLow;
    logic memDone;

    controlUnit control (
        .Clock   (Clock),
        .rstN    (rstN),
        .instr   (instr),
        .memDone (memDone),
        .ctrl    (ctrl),
        .halted  (halted)
    );

    memInterface #(
        .ADDR_W (ADDR_W)
    ) memIf (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .bus      (bus),
        .memAck   (memAck),
        .memData  (memData),
        .memReq   (memReq),
        .memCmd   (memCmd),
        .memDone  (memDone),
        .pcValue  (pcValue),
        .mdrValue (mdrValue)
    );

    registerFile regFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .bus     (bus),
        .regData (regData)
    );

    aluUnit alu (
        .Clock (Clock),
        .rstN  (rstN),
        .ctrl  (ctrl),
        .bus   (bus),
        .zLow  (zLow)
    );

    busRouter router (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .regData  (regData),
        .pcValue  (pcValue),
        .mdrValue (mdrValue),
        .zLow     (zLow),
        .bus      (bus),
        .instr    (instr)
    );

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                          Clock,
    input  logic                          rstN,
    input  minisrcPkg::ctrlWord_t         ctrl,
    input  logic [minisrcPkg::DATA_W-1:0] bus,
    output logic [minisrcPkg::DATA_W-1:0] regData
);

    logic [minisrcPkg::DATA_W-1:0] regs [minisrcPkg::REG_CNT];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < minisrcPkg::REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[ctrl.regIndex] <= bus;
        end
    end

    // base register R0 reads as zero for ld, ldi and st
    always_comb begin
        if (ctrl.baGate && ctrl.regIndex == '0) regData = '0;
        else regData = regs[ctrl.regIndex];
    end

endmodule

`default_nettype wire

/* minisrc.f */
+incdir+verif
hdl/minisrcPkg.sv
hdl/controlUnit.sv
hdl/memInterface.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/busRouter.sv
hdl/minisrcTop.sv
verif/minisrcTb.sv

/* verif/minisrcModel.svh */
`ifndef MINISRC_MODEL_SVH
`define MINISRC_MODEL_SVH

// one memory access as the DUT should issue it, data matters for writes only
typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
} access_t;

logic [31:0] modelMem [MEM_WORDS];
logic [31:0] modelRegs [16];
access_t expAccesses [$];
int expWrites;

function automatic logic [31:0] encodeReg(minisrcPkg::opcode_t op, int ra, int rb, int rc);
    return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
endfunction

function automatic logic [31:0] encodeImm(minisrcPkg::opcode_t op, int ra, int rb, int c);
    return {op, ra[3:0], rb[3:0], c[18:0]};
endfunction

function automatic logic [31:0] wordAddr(logic [31:0] a);
    return a & 32'(MEM_WORDS - 1); // memory only decodes the low address bits
endfunction

function automatic void expectAccess(logic write, logic [31:0] addr, logic [31:0] data);
    access_t acc;
    acc.write = write;
    acc.addr = wordAddr(addr);
    acc.data = data;
    expAccesses.push_back(acc);
endfunction

function automatic logic [31:0] aluResult(minisrcPkg::opcode_t op, logic [31:0] a,
                                          logic [31:0] b);
    int n;
    n = b[4:0];
    case (op)
        minisrcPkg::opAdd:  return a + b;
        minisrcPkg::opSub:  return a - b;
        minisrcPkg::opAnd:  return a & b;
        minisrcPkg::opOr:   return a | b;
        minisrcPkg::opShr:  return a >> n;
        minisrcPkg::opShra: return $unsigned($signed(a) >>> n);
        minisrcPkg::opShl:  return a << n;
        minisrcPkg::opRor:  return (n == 0) ? a : ((a >> n) | (a << (32 - n)));
        minisrcPkg::opRol:  return (n == 0) ? a : ((a << n) | (a >> (32 - n)));
        default:            return a;
    endcase
endfunction

// runs the program in modelMem and lists every access the DUT should make
task automatic runModel;
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] ea;
    logic [3:0] ra;
    logic [3:0] rb;
    logic [3:0] rc;
    minisrcPkg::opcode_t op;
    int executed;
    int r;
    bit stop;
    pc = '0;
    executed = 0;
    stop = 1'b0;
    expWrites = 0;
    expAccesses.delete();
    for (r = 0; r < 16; r++) begin
        modelRegs[r] = '0;
    end
    while (!stop && executed < 4 * PROG_LEN) begin
        word = modelMem[wordAddr(pc)];
        expectAccess(1'b0, pc, '0); // instruction fetch
        pc = pc + 1;
        executed++;
        op = minisrcPkg::opcode_t'(word[31:27]);
        ra = word[26:23];
        rb = word[22:19];
        rc = word[18:15];
        ea = ((rb == 4'd0) ? 32'd0 : modelRegs[rb]) + {{13{word[18]}}, word[18:0]};
        case (op)
            minisrcPkg::opLd: begin
                expectAccess(1'b0, ea, '0);
                modelRegs[ra] = modelMem[wordAddr(ea)];
            end
            minisrcPkg::opLdi: modelRegs[ra] = ea;
            minisrcPkg::opSt: begin
                expectAccess(1'b1, ea, modelRegs[ra]);
                modelMem[wordAddr(ea)] = modelRegs[ra];
                expWrites++;
            end
            minisrcPkg::opAdd, minisrcPkg::opSub, minisrcPkg::opAnd, minisrcPkg::opOr,
            minisrcPkg::opShr, minisrcPkg::opShra, minisrcPkg::opShl, minisrcPkg::opRor,
            minisrcPkg::opRol: modelRegs[ra] = aluResult(op, modelRegs[rb], modelRegs[rc]);
            minisrcPkg::opHalt: stop = 1'b1;
            default: ; // fetch only
        endcase
    end
endtask

`endif

/* verif/minisrcTb.sv */
`timescale 1ns/1ps
`default_nettype none

module minisrcTb;

    localparam int ADDR_W = 12;
    localparam int MEM_WORDS = 1 << ADDR_W;
    localparam int PROG_LEN = 64;
    localparam int MAX_DELAY = 4;
    localparam int CYCLE_LIMIT = PROG_LEN * (8 + 2 * (2 * MAX_DELAY + 4)) + 100;
    localparam int DATA_BASE = 32'h800;
    localparam int PTR_BASE = 32'h900;

    logic Clock;
    logic rstN;
    logic memAck;
    logic [31:0] memData;
    logic memReq;
    logic halted;
    minisrcPkg::memCmd_t memCmd;

    `include "minisrcModel.svh"

    logic [31:0] mem [MEM_WORDS];
    int seed;
    int errors;
    int accessIdx;
    int writeCount;
    int cycles;
    logic reqPrev;
    logic ackPrev;
    minisrcPkg::memCmd_t cmdPrev;

    minisrcTop #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .Clock   (Clock),
        .rstN    (rstN),
        .memAck  (memAck),
        .memData (memData),
        .memReq  (memReq),
        .memCmd  (memCmd),
        .halted  (halted)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    function automatic logic [31:0] fillWord(int a);
        return (32'(a) * 32'h9E3779B1) ^ 32'h5A5A5A5A; // odd multiplier so every address bit counts
    endfunction

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic placeInstr(inout int idx, input logic [31:0] word);
        mem[idx] = word;
        modelMem[idx] = word;
        idx++;
    endtask

    task automatic buildProgram;
        minisrcPkg::opcode_t aluOps [9];
        minisrcPkg::opcode_t op;
        int idx;
        int i;
        int c;
        int ra;
        int rb;
        int rc;
        aluOps = '{minisrcPkg::opAdd, minisrcPkg::opSub, minisrcPkg::opAnd, minisrcPkg::opOr,
                   minisrcPkg::opShr, minisrcPkg::opShra, minisrcPkg::opShl,
                   minisrcPkg::opRor, minisrcPkg::opRol};
        idx = 0;
        for (i = 1; i <= 12; i++) begin
            c = $random(seed);
            if (i % 3 == 0) c[18] = 1'b1; // negative constant
            placeInstr(idx, encodeImm(minisrcPkg::opLdi, i, 0, c));
        end
        placeInstr(idx, encodeImm(minisrcPkg::opLdi, 14, 0, PTR_BASE)); // pointer for ld/st
        for (i = 0; i < 24; i++) begin
            op = aluOps[randBelow(9)];
            ra = 1 + randBelow(13);
            rb = randBelow(16);
            rc = randBelow(16);
            if (i == 0) begin
                c = 1 + randBelow(1024);
                placeInstr(idx, encodeImm(minisrcPkg::opLdi, 0, 0, c)); // nonzero R0
            end else if (i == 7) begin
                placeInstr(idx, encodeReg(minisrcPkg::opShl, 1, 3, 5)); // 489A8000
            end else begin
                placeInstr(idx, encodeReg(op, ra, rb, rc));
            end
        end
        for (i = 0; i < 16; i++) begin
            placeInstr(idx, encodeImm(minisrcPkg::opSt, i, 0, DATA_BASE + i));
        end
        c = -(1 + randBelow(64));
        placeInstr(idx, encodeImm(minisrcPkg::opLd, 2, 0, c)); // wraps to the top of memory
        placeInstr(idx, encodeImm(minisrcPkg::opSt, 2, 0, DATA_BASE + 16));
        placeInstr(idx, encodeImm(minisrcPkg::opSt, 7, 14, 3));
        placeInstr(idx, encodeImm(minisrcPkg::opLd, 9, 14, 3));
        placeInstr(idx, encodeImm(minisrcPkg::opSt, 9, 0, DATA_BASE + 17));
        c = -(1 + randBelow(32'h3FFFF));
        placeInstr(idx, encodeImm(minisrcPkg::opLdi, 10, 0, c));
        placeInstr(idx, encodeImm(minisrcPkg::opSt, 10, 0, DATA_BASE + 18));
        placeInstr(idx, encodeImm(minisrcPkg::opLd, 11, 0, DATA_BASE + 1));
        placeInstr(idx, encodeReg(minisrcPkg::opAdd, 12, 11, 9));
        placeInstr(idx, encodeImm(minisrcPkg::opSt, 12, 0, DATA_BASE + 19));
        placeInstr(idx, encodeReg(minisrcPkg::opHalt, 0, 0, 0));
    endtask

    // called at a falling edge with memReq high
    task automatic serveRequest;
        access_t want;
        logic [ADDR_W-1:0] a;
        repeat (randBelow(MAX_DELAY + 1)) @(negedge Clock);
        a = memCmd.addr[ADDR_W-1:0];
        if (accessIdx >= expAccesses.size()) begin
            $display("ERROR: request %0d is more than the model's %0d accesses",
                     accessIdx, expAccesses.size());
            errors++;
        end else begin
            want = expAccesses[accessIdx];
            if (memCmd.write !== want.write) begin
                $display("CHECK FAILED memCmd.write: got %h expected %h (access %0d)",
                         memCmd.write, want.write, accessIdx);
                errors++;
            end
            if (memCmd.addr !== want.addr) begin
                $display("CHECK FAILED memCmd.addr: got %h expected %h (access %0d)",
                         memCmd.addr, want.addr, accessIdx);
                errors++;
            end
            if (want.write && memCmd.wdata !== want.data) begin
                $display("CHECK FAILED memCmd.wdata: got %h expected %h (access %0d)",
                         memCmd.wdata, want.data, accessIdx);
                errors++;
            end
        end
        accessIdx++;
        if (memCmd.write) begin
            mem[a] = memCmd.wdata;
            writeCount++;
        end else begin
            memData = mem[a];
        end
        memAck = 1'b1;
        @(negedge Clock);
        while (memReq) @(negedge Clock);
        repeat (randBelow(MAX_DELAY + 1)) @(negedge Clock);
        memAck = 1'b0;
    endtask

    // handshake rules on the values from before this edge's updates
    always @(posedge Clock) begin
        if (rstN) begin
            if (memReq && !reqPrev && ackPrev) begin
                $display("ERROR: memReq rose while memAck was still high");
                errors++;
            end
            if (memReq && reqPrev && memCmd !== cmdPrev) begin
                $display("CHECK FAILED memCmd: got %h expected %h", memCmd, cmdPrev);
                errors++;
            end
            if (memAck && !ackPrev && !memReq) begin
                $display("ERROR: memAck rose with no request pending");
                errors++;
            end
        end
        reqPrev = memReq;
        ackPrev = memAck;
        cmdPrev = memCmd;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge Clock);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
        errors++;
        $display("errors: %0d  accesses: %0d  writes: %0d", errors, accessIdx, writeCount);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int a;
        rstN = 1'b0;
        memAck = 1'b0;
        memData = '0;
        seed = 30192;
        errors = 0;
        accessIdx = 0;
        writeCount = 0;
        reqPrev = 1'b0;
        ackPrev = 1'b0;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fillWord(a);
            modelMem[a] = fillWord(a);
        end
        buildProgram();
        runModel();
        repeat (3) @(negedge Clock);
        rstN = 1'b1;
        if (memReq !== 1'b0) begin
            $display("CHECK FAILED memReq after reset: got %h expected 0", memReq);
            errors++;
        end
        if (halted !== 1'b0) begin
            $display("CHECK FAILED halted after reset: got %h expected 0", halted);
            errors++;
        end
        while (halted !== 1'b1) begin
            @(negedge Clock);
            if (memReq === 1'b1) serveRequest();
        end
        if (accessIdx != expAccesses.size()) begin
            $display("ERROR: halted after %0d accesses, the model made %0d",
                     accessIdx, expAccesses.size());
            errors++;
        end
        repeat (20) begin
            @(negedge Clock);
            if (memReq !== 1'b0) begin
                $display("ERROR: memory request after halt");
                errors++;
            end
        end
        if (writeCount != expWrites) begin
            $display("CHECK FAILED write count: got %h expected %h", writeCount, expWrites);
            errors++;
        end
        for (a = 0; a < MEM_WORDS; a++) begin
            if (mem[a] !== modelMem[a]) begin
                $display("CHECK FAILED mem[%h]: got %h expected %h", a, mem[a], modelMem[a]);
                errors++;
            end
        end
        $display("errors: %0d  accesses: %0d  writes: %0d", errors, accessIdx, writeCount);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
